/* filelist.f */
source/pcs_line_pkg.sv
source/pcs_monitor_pkg.sv
source/block_sync.sv
source/ber_monitor.sv
source/descrambler.sv
source/block_decoder.sv
source/pcs_rx_top.sv
testbench/tb_clock_gen.sv
testbench/pcs_rx_sva.sv
testbench/pcs_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the receive path testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pcs_rx_tb -f filelist.f -o pcs_rx_sim \
    && ./obj_dir/pcs_rx_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run returned an error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

/* testbench/pcs_rx_tb.sv */
`timescale 1ns/1ps
// receive path testbench with a seeded block generator, a scrambler and decoder model and checks
module pcs_rx_tb
    import pcs_line_pkg::*, pcs_monitor_pkg::*;
();
    localparam int LOCK_WAIT   = 66 * 65;
    localparam int N_TRAFFIC   = 2200;
    localparam int N_ERRORS    = 300;
    localparam int N_BER       = 2176;
    localparam int N_BYPASS    = 300;
    localparam int N_RELOCK    = 300;
    localparam int MAX_BLOCKS  = 20000;
    localparam int CYCLE_LIMIT = 2 * LOCK_WAIT + N_TRAFFIC + N_ERRORS + 2 * N_BER
                               + N_BYPASS + N_RELOCK + 200;

    logic                    clock;
    logic                    reset;
    logic                    valid;
    logic [NB_BLOCK-1:0]     phy_data;
    logic                    signal_ok;
    logic                    bypass;
    logic                    rx_valid;
    logic [NB_PAYLOAD-1:0]   rx_data;
    logic [NB_CTRL-1:0]      rx_ctrl;
    logic                    block_lock;
    logic                    hi_ber;
    logic [NB_ERR_COUNT-1:0] err_count;

    integer                  seed = 32'h5584_98dc;
    int                      off;
    int                      word_idx;
    int                      cycles;
    int                      errors;
    int                      checks;
    int                      test_start;
    int                      tests_passed;
    int                      tests_failed;
    logic                    bypass_mode;
    logic                    prev_rx_valid;
    logic [NB_BLOCK-1:0]     prev_blk;
    logic [SCR_TAP_HIGH-1:0] tx_hist;                 // [0] is the most recent line bit
    logic [NB_PAYLOAD-1:0]   exp_data [MAX_BLOCKS];
    logic [NB_CTRL-1:0]      exp_ctrl [MAX_BLOCKS];
    logic                    exp_byp  [MAX_BLOCKS];

    tb_clock_gen clock_gen_i (.o_clock(clock), .o_reset(reset));

    pcs_rx_top dut_i (
        .i_clock               (clock),
        .i_reset               (reset),
        .i_valid               (valid),
        .i_phy_data            (phy_data),
        .i_signal_ok           (signal_ok),
        .i_descrambler_bypass  (bypass),
        .o_valid               (rx_valid),
        .o_rx_data             (rx_data),
        .o_rx_ctrl             (rx_ctrl),
        .o_block_lock          (block_lock),
        .o_hi_ber              (hi_ber),
        .o_decoder_error_count (err_count)
    );

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // output seen now belongs to the block completed by the word sent three words back
    task automatic check_outputs();
        int k;
        k = word_idx - 4;
        if (rx_valid && prev_rx_valid && k >= 0)
        begin
            checks++;
            if (rx_data !== exp_data[k] || rx_ctrl !== exp_ctrl[k])
            begin
                errors++;
                $display("MISMATCH at %0t: block %0d gave %h/%h, expected %h/%h",
                         $time, k, rx_data, rx_ctrl, exp_data[k], exp_ctrl[k]);
            end
        end
        prev_rx_valid = rx_valid;   // first block after lock has no descrambler history
    endtask

    // kind 0 legal block, 1 unknown type, 2 bad sync header
    task automatic send_block(input int kind);
        logic [NB_PAYLOAD-1:0]   plain;
        logic [NB_PAYLOAD-1:0]   sent;
        logic [NB_SH-1:0]        sh;
        logic [7:0]              btype;
        logic [2*NB_BLOCK-1:0]   pair;
        int                      pick;
        plain = rand64();
        pick  = $unsigned($random(seed)) % 4;
        sh    = SH_CTRL;
        if (kind == 1)
        begin
            btype = 8'($random(seed));
            while (btype == BT_IDLE || btype == BT_START || btype == BT_TERM)
                btype = btype + 8'd1;
            plain[7:0] = btype;
            exp_data[word_idx] = {8{CHAR_ERROR}};
            exp_ctrl[word_idx] = 8'hFF;
        end
        else if (pick == 0)
        begin
            sh = SH_DATA;
            exp_data[word_idx] = plain;
            exp_ctrl[word_idx] = 8'h00;
        end
        else if (pick == 1)
        begin
            plain[7:0] = BT_IDLE;
            exp_data[word_idx] = {8{CHAR_IDLE}};
            exp_ctrl[word_idx] = 8'hFF;
        end
        else if (pick == 2)
        begin
            plain[7:0] = BT_START;
            exp_data[word_idx] = {plain[63:8], CHAR_START};
            exp_ctrl[word_idx] = 8'h01;
        end
        else
        begin
            plain[7:0] = BT_TERM;
            exp_data[word_idx] = {CHAR_TERM, plain[63:8]};
            exp_ctrl[word_idx] = 8'h80;
        end
        if (kind == 2)
        begin
            sh = ($random(seed) & 1) ? 2'b11 : 2'b00;
            exp_data[word_idx] = {8{CHAR_ERROR}};
            exp_ctrl[word_idx] = 8'hFF;
        end
        // s = p ^ s[-39] ^ s[-58] over the line bits
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            sent[i] = bypass_mode ? plain[i]
                                  : plain[i] ^ tx_hist[SCR_TAP_LOW-1] ^ tx_hist[SCR_TAP_HIGH-1];
            tx_hist = {tx_hist[SCR_TAP_HIGH-2:0], sent[i]};
        end
        exp_byp[word_idx] = bypass_mode;
        pair = {sent, sh, prev_blk} >> (NB_BLOCK - off);
        @(negedge clock);
        check_outputs();
        valid    = 1'b1;
        phy_data = pair[NB_BLOCK-1:0];
        bypass   = (word_idx >= 2) ? exp_byp[word_idx-2] : 1'b0;
        prev_blk = {sent, sh};
        word_idx++;
    endtask

    task automatic expect_bit(input logic actual, input logic wanted, input string what);
        if (actual !== wanted)
        begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, actual, wanted);
        end
    endtask

    task automatic wait_lock();
        int n;
        n = 0;
        while (!block_lock && n < LOCK_WAIT + 2)
        begin
            send_block(0);
            n++;
        end
        if (!block_lock)
        begin
            errors++;
            $display("block lock was not reached within %0d words", LOCK_WAIT);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    always @(posedge clock)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial
    begin
        int base;
        int injected;
        valid         = 1'b0;
        phy_data      = '0;
        signal_ok     = 1'b1;
        bypass        = 1'b0;
        bypass_mode   = 1'b0;
        prev_rx_valid = 1'b0;
        off           = $unsigned($random(seed)) % NB_BLOCK;
        prev_blk      = {2'b00, rand64()};
        tx_hist       = 58'(rand64());
        while (reset)
            @(negedge clock);

        wait_lock();
        expect_bit(hi_ber, 1'b0, "hi ber during lock acquisition");
        end_test("lock acquisition");

        for (int i = 0; i < N_TRAFFIC; i++)
            send_block(0);
        expect_bit(hi_ber, 1'b0, "hi ber after clean traffic");
        expect_bit(block_lock, 1'b1, "block lock");
        end_test("random traffic");

        base     = int'(err_count);
        injected = 0;
        for (int i = 0; i < N_ERRORS; i++)
        begin
            send_block((i % 6 == 0) ? 1 : 0);
            injected += (i % 6 == 0) ? 1 : 0;
        end
        repeat (5) send_block(0);
        if (int'(err_count) - base != injected)
        begin
            errors++;
            $display("MISMATCH at %0t: error count rose by %0d, expected %0d",
                     $time, int'(err_count) - base, injected);
        end
        end_test("unknown block types");

        for (int i = 0; i < N_BER; i++)
            send_block((i % 64 < 7) ? 2 : 0);
        expect_bit(block_lock, 1'b1, "block lock under bad headers");
        expect_bit(hi_ber, 1'b1, "hi ber under bad headers");
        for (int i = 0; i < N_BER; i++)
            send_block(0);
        expect_bit(hi_ber, 1'b0, "hi ber after recovery");
        end_test("ber monitor");

        bypass_mode = 1'b1;
        for (int i = 0; i < N_BYPASS; i++)
            send_block(0);
        bypass_mode = 1'b0;
        repeat (8) send_block(0);
        end_test("descrambler bypass");

        signal_ok = 1'b0;
        repeat (4) send_block(0);
        expect_bit(block_lock, 1'b0, "block lock after signal loss");
        repeat (10)
        begin
            send_block(0);
            expect_bit(rx_valid, 1'b0, "output valid without signal");
        end
        signal_ok = 1'b1;
        wait_lock();
        for (int i = 0; i < N_RELOCK; i++)
            send_block(0);
        end_test("signal loss and relock");

        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* testbench/pcs_rx_sva.sv */
`timescale 1ns/1ps
// receive path assertions: output valid gated by lock, fixed latency, ber flag timing
module pcs_rx_sva
    import pcs_monitor_pkg::*;
(
    input logic i_clock,
    input logic i_reset,
    input logic i_valid,
    input logic i_sh_valid,
    input logic o_valid,
    input logic o_block_lock,
    input logic o_hi_ber
);
    logic [NB_BER_COUNT-1:0] hdr_count;
    logic                    window_end;

    assign window_end = i_sh_valid && (hdr_count == NB_BER_COUNT'(BER_WINDOW - 1));

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            hdr_count <= '0;
        else if (i_sh_valid)
            hdr_count <= hdr_count + 1'b1;   // wraps at the window size
    end

    // the two later stages still hold blocks taken while locked
    assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid |-> $past(o_block_lock, 2))
        else $error("output valid without block lock");

    assert property (@(posedge i_clock) disable iff (i_reset)
        (i_valid && o_block_lock) ##1 o_block_lock |-> ##2 o_valid)
        else $error("output valid missing three cycles after input");

    assert property (@(posedge i_clock) disable iff (i_reset)
        $changed(o_hi_ber) |-> $past(window_end))
        else $error("hi ber flag changed away from a window end");

endmodule

bind pcs_rx_top pcs_rx_sva sva_i (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_sh_valid   (sync_sh_valid),
    .o_valid      (o_valid),
    .o_block_lock (o_block_lock),
    .o_hi_ber     (o_hi_ber)
);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
// testbench clock and reset: 20 ns clock, reset held for the first 10 cycles
module tb_clock_gen
(
    output logic o_clock,
    output logic o_reset
);
    initial
    begin
        o_clock = 1'b0;
        o_reset = 1'b1;
        repeat (10) @(posedge o_clock);
        @(negedge o_clock);
        o_reset = 1'b0;
    end

    always #10 o_clock = ~o_clock;

endmodule

/* source/pcs_rx_top.sv */
`timescale 1ns/1ps
// pcs receive top: block sync, ber monitor, descrambler and decoder for one 64b/66b lane
module pcs_rx_top
    import pcs_line_pkg::*, pcs_monitor_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  logic [NB_BLOCK-1:0]     i_phy_data,
    input  logic                    i_signal_ok,
    input  logic                    i_descrambler_bypass,
    output logic                    o_valid,
    output logic [NB_PAYLOAD-1:0]   o_rx_data,
    output logic [NB_CTRL-1:0]      o_rx_ctrl,
    output logic                    o_block_lock,
    output logic                    o_hi_ber,
    output logic [NB_ERR_COUNT-1:0] o_decoder_error_count
);
    // block sync to descrambler and ber monitor
    logic                sync_valid;
    logic [NB_BLOCK-1:0] sync_block;
    logic                sync_sh_valid;
    logic                sync_sh_good;

    // descrambler to decoder
    logic                descr_valid;
    logic [NB_BLOCK-1:0] descr_block;

    block_sync u_block_sync (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_phy_data   (i_phy_data),
        .i_signal_ok  (i_signal_ok),
        .o_valid      (sync_valid),
        .o_block      (sync_block),
        .o_block_lock (o_block_lock),
        .o_sh_valid   (sync_sh_valid),
        .o_sh_good    (sync_sh_good)
    );

    ber_monitor u_ber_monitor (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_sh_valid (sync_sh_valid),
        .i_sh_good  (sync_sh_good),
        .o_hi_ber   (o_hi_ber)
    );

    descrambler u_descrambler (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (sync_valid),
        .i_block  (sync_block),
        .i_bypass (i_descrambler_bypass),
        .i_lock   (o_block_lock),   // state restarts on lock loss
        .o_valid  (descr_valid),
        .o_block  (descr_block)
    );

    block_decoder u_block_decoder (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (descr_valid),
        .i_block       (descr_block),
        .o_valid       (o_valid),
        .o_rx_data     (o_rx_data),
        .o_rx_ctrl     (o_rx_ctrl),
        .o_error_count (o_decoder_error_count)
    );

endmodule

/* source/block_decoder.sv */
`timescale 1ns/1ps
// block decoder: turns 66-bit blocks into 64 data and 8 control bits and counts bad blocks
module block_decoder
    import pcs_line_pkg::*, pcs_monitor_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  logic [NB_BLOCK-1:0]     i_block,
    output logic                    o_valid,
    output logic [NB_PAYLOAD-1:0]   o_rx_data,
    output logic [NB_CTRL-1:0]      o_rx_ctrl,
    output logic [NB_ERR_COUNT-1:0] o_error_count
);
    logic [NB_SH-1:0]      header;
    logic [NB_PAYLOAD-1:0] payload;
    block_type_e           block_type;
    logic [NB_PAYLOAD-1:0] dec_data;
    logic [NB_CTRL-1:0]    dec_ctrl;
    logic                  dec_error;

    assign header     = i_block[NB_SH-1:0];
    assign payload    = i_block[NB_BLOCK-1:NB_SH];
    assign block_type = block_type_e'(payload[7:0]);

    always_comb
    begin
        dec_data  = {NB_CTRL{CHAR_ERROR}};
        dec_ctrl  = '1;
        dec_error = 1'b0;
        if (header == SH_DATA)
        begin
            dec_data = payload;
            dec_ctrl = '0;
        end
        else if (header == SH_CTRL)
        begin
            case (block_type)
                BT_IDLE:
                begin
                    dec_data = {NB_CTRL{CHAR_IDLE}};
                    dec_ctrl = '1;
                end
                BT_START:
                begin
                    // lane 0 is the start, the type byte is not carried
                    dec_data = {payload[NB_PAYLOAD-1:8], CHAR_START};
                    dec_ctrl = {{(NB_CTRL-1){1'b0}}, 1'b1};
                end
                BT_TERM:
                begin
                    dec_data = {CHAR_TERM, payload[NB_PAYLOAD-1:8]};
                    dec_ctrl = {1'b1, {(NB_CTRL-1){1'b0}}};   // terminate in lane 7
                end
                default:
                begin
                    dec_error = 1'b1;   // unknown block type
                end
            endcase
        end
        else
        begin
            dec_error = 1'b1;   // 00 or 11 header
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid       <= 1'b0;
            o_error_count <= '0;
        end
        else
        begin
            o_valid <= i_valid;
            if (i_valid && dec_error && (o_error_count != '1))
                o_error_count <= o_error_count + 1'b1;   // saturates
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_rx_data <= dec_data;
            o_rx_ctrl <= dec_ctrl;
        end
    end

endmodule

/* source/descrambler.sv */
`timescale 1ns/1ps
// descrambler: self-synchronizing x^58 + x^39 + 1 payload descrambler with bypass
module descrambler
    import pcs_line_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_valid,
    input  logic [NB_BLOCK-1:0] i_block,
    input  logic                i_bypass,
    input  logic                i_lock,
    output logic                o_valid,
    output logic [NB_BLOCK-1:0] o_block
);
    logic [SCR_TAP_HIGH-1:0]            scr_state;     // msb is the most recent bit
    logic [NB_PAYLOAD+SCR_TAP_HIGH-1:0] ext;
    logic [NB_PAYLOAD-1:0]              descrambled;

    // history below, new scrambled payload on top
    assign ext = {i_block[NB_BLOCK-1:NB_SH], scr_state};

    assign descrambled = ext[SCR_TAP_HIGH +: NB_PAYLOAD]
                       ^ ext[SCR_TAP_HIGH - SCR_TAP_LOW +: NB_PAYLOAD]
                       ^ ext[0 +: NB_PAYLOAD];

    always_ff @(posedge i_clock)
    begin
        if (i_reset || !i_lock)
            scr_state <= '0;
        else if (i_valid)
            scr_state <= ext[NB_PAYLOAD +: SCR_TAP_HIGH];   // shifts in bypass too
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_block[NB_SH-1:0]          <= i_block[NB_SH-1:0];
            o_block[NB_BLOCK-1:NB_SH]   <= i_bypass ? i_block[NB_BLOCK-1:NB_SH] : descrambled;
        end
    end

endmodule

/* source/ber_monitor.sv */
`timescale 1ns/1ps
// ber monitor: counts bad sync headers per window and flags a high bit error rate
module ber_monitor
    import pcs_monitor_pkg::*;
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_sh_valid,
    input  logic i_sh_good,
    output logic o_hi_ber
);
    logic [NB_BER_COUNT-1:0] hdr_count;
    logic [NB_BER_BAD-1:0]   bad_count;
    logic [NB_BER_BAD-1:0]   bad_count_next;
    logic                    bad_saturated;
    logic                    window_end;

    // no need to count past the limit
    assign bad_saturated  = (bad_count == NB_BER_BAD'(HI_BER_LIMIT));
    assign bad_count_next = (!i_sh_good && !bad_saturated) ? bad_count + 1'b1 : bad_count;
    assign window_end     = (hdr_count == NB_BER_COUNT'(BER_WINDOW - 1));

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            hdr_count <= '0;
            bad_count <= '0;
            o_hi_ber  <= 1'b0;
        end
        else if (i_sh_valid)
        begin
            if (window_end)
            begin
                // decision includes the last header of the window
                o_hi_ber  <= (bad_count_next == NB_BER_BAD'(HI_BER_LIMIT));
                hdr_count <= '0;
                bad_count <= '0;
            end
            else
            begin
                hdr_count <= hdr_count + 1'b1;
                bad_count <= bad_count_next;
            end
        end
    end

endmodule

/* source/block_sync.sv */
`timescale 1ns/1ps
// block sync: bit-slip gearbox with sync header lock state machine
module block_sync
    import pcs_line_pkg::*, pcs_monitor_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_valid,
    input  logic [NB_BLOCK-1:0] i_phy_data,
    input  logic                i_signal_ok,
    output logic                o_valid,
    output logic [NB_BLOCK-1:0] o_block,
    output logic                o_block_lock,
    output logic                o_sh_valid,
    output logic                o_sh_good
);
    logic [NB_BLOCK-1:0]     prev_word;
    logic                    prev_loaded;
    logic [2*NB_BLOCK-1:0]   stream;
    logic [NB_BLOCK-1:0]     window;
    logic                    hdr_valid;
    logic                    hdr_good;
    logic [NB_SLIP-1:0]      slip_advanced;
    lock_state_e             state;
    lock_state_e             state_next;
    logic [NB_SLIP-1:0]      slip;
    logic [NB_SLIP-1:0]      slip_next;
    logic [NB_SH_COUNT-1:0]  sh_count;
    logic [NB_SH_COUNT-1:0]  sh_count_next;
    logic [NB_INV_COUNT-1:0] inv_count;
    logic [NB_INV_COUNT-1:0] inv_count_next;

    assign stream    = {i_phy_data, prev_word};   // older word in the low half
    assign window    = stream[slip +: NB_BLOCK];
    assign hdr_valid = i_valid && prev_loaded;
    assign hdr_good  = (window[NB_SH-1:0] == SH_DATA) || (window[NB_SH-1:0] == SH_CTRL);

    assign slip_advanced = (slip == NB_SLIP'(NB_BLOCK - 1)) ? '0 : slip + 1'b1;

    always_comb
    begin
        state_next     = state;
        slip_next      = slip;
        sh_count_next  = sh_count;
        inv_count_next = inv_count;
        if (!i_signal_ok)
        begin
            state_next     = LOCK_SEARCH;
            sh_count_next  = '0;
            inv_count_next = '0;
        end
        else if (hdr_valid)
        begin
            case (state)
                LOCK_SEARCH, LOCK_TEST:
                begin
                    if (!hdr_good)
                    begin
                        state_next    = LOCK_SEARCH;
                        slip_next     = slip_advanced;   // try the next bit offset
                        sh_count_next = '0;
                    end
                    else if (sh_count == NB_SH_COUNT'(SH_LOCK_COUNT - 1))
                    begin
                        state_next     = LOCK_LOCKED;
                        sh_count_next  = '0;
                        inv_count_next = '0;
                    end
                    else
                    begin
                        state_next    = LOCK_TEST;
                        sh_count_next = sh_count + 1'b1;
                    end
                end
                default:
                begin
                    if (!hdr_good && inv_count == NB_INV_COUNT'(SH_INVALID_LIMIT - 1))
                    begin
                        state_next     = LOCK_SEARCH;
                        sh_count_next  = '0;
                        inv_count_next = '0;
                    end
                    else if (sh_count == NB_SH_COUNT'(SH_WINDOW - 1))
                    begin
                        sh_count_next  = '0;   // window done, start over
                        inv_count_next = '0;
                    end
                    else
                    begin
                        sh_count_next  = sh_count + 1'b1;
                        inv_count_next = inv_count + NB_INV_COUNT'(!hdr_good);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state       <= LOCK_SEARCH;
            slip        <= '0;
            sh_count    <= '0;
            inv_count   <= '0;
            prev_loaded <= 1'b0;
            o_valid     <= 1'b0;
            o_sh_valid  <= 1'b0;
            o_sh_good   <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            slip        <= slip_next;
            sh_count    <= sh_count_next;
            inv_count   <= inv_count_next;
            prev_loaded <= prev_loaded | i_valid;
            o_valid     <= hdr_valid && (state_next == LOCK_LOCKED);
            o_sh_valid  <= hdr_valid;
            o_sh_good   <= hdr_good;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            prev_word <= i_phy_data;
            o_block   <= window;
        end
    end

    assign o_block_lock = (state == LOCK_LOCKED);

endmodule

/* source/pcs_monitor_pkg.sv */
// link monitor package: lock and BER thresholds, counter widths and the lock state encoding
package pcs_monitor_pkg;

    // block lock thresholds
    localparam int SH_LOCK_COUNT    = 64;     // good headers in a row to lock
    localparam int SH_WINDOW        = 64;     // headers per window while locked
    localparam int SH_INVALID_LIMIT = 16;     // bad headers per window that drop lock

    // ber monitor thresholds
    localparam int BER_WINDOW   = 1024;
    localparam int HI_BER_LIMIT = 97;

    // counter widths
    localparam int NB_SLIP      = 7;          // slip offset 0..65
    localparam int NB_SH_COUNT  = $clog2(SH_LOCK_COUNT);
    localparam int NB_INV_COUNT = $clog2(SH_INVALID_LIMIT);
    localparam int NB_BER_COUNT = $clog2(BER_WINDOW);
    localparam int NB_BER_BAD   = $clog2(HI_BER_LIMIT + 1);
    localparam int NB_ERR_COUNT = 16;

    typedef enum logic [1:0] {
        LOCK_SEARCH,
        LOCK_TEST,
        LOCK_LOCKED
    } lock_state_e;

endpackage

/* source/pcs_line_pkg.sv */
// 64b/66b line code package: block widths, sync headers, scrambler taps and control codes
package pcs_line_pkg;

    // coded block layout
    localparam int NB_BLOCK   = 66;
    localparam int NB_SH      = 2;
    localparam int NB_PAYLOAD = 64;
    localparam int NB_CTRL    = 8;

    // sync header values as seen in block[1:0], bit 0 first on the line
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    // x^58 + x^39 + 1
    localparam int SCR_TAP_HIGH = 58;
    localparam int SCR_TAP_LOW  = 39;

    // block type field, first payload byte of a control block
    typedef enum logic [7:0] {
        BT_IDLE  = 8'h1E,   // eight idles
        BT_START = 8'h78,   // start, seven data bytes
        BT_TERM  = 8'hFF    // seven data bytes, terminate
    } block_type_e;

    // xgmii-style lane characters
    localparam logic [7:0] CHAR_IDLE  = 8'h07;
    localparam logic [7:0] CHAR_START = 8'hFB;
    localparam logic [7:0] CHAR_TERM  = 8'hFD;
    localparam logic [7:0] CHAR_ERROR = 8'hFE;

endpackage
